//--- Makefile
# Verilator lint and simulation of the pipelined core

TOP := arm_pipeline_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

# the run passes only when the pass message shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir

//--- hdl/arm_pipeline.sv
/* five-stage pipelined core
   fetch, decode, execute, memory and write-back with host load and trace */

`timescale 1ns/1ps
`include "cpu_consts.svh"

module arm_pipeline
(
   input  logic                      clock,
   input  logic                      reset,
   input  logic                      host_mode_i,
   input  cpu_pkg::imem_write_t      imem_write_i,
   input  logic [`CPU_DMEM_BITS-1:0] dmem_addr_i,
   output logic [`CPU_XLEN-1:0]      dmem_data_o,
   output cpu_pkg::wb_trace_t        trace_o
);

   cpu_pkg::if_id_t           if_id;
   cpu_pkg::id_ex_t           id_ex;
   cpu_pkg::ex_mem_t          ex_mem;
   cpu_pkg::wb_trace_t        wb;
   logic                      stall;
   logic                      branch_taken;
   logic [`CPU_IMEM_BITS-1:0] branch_target;

   fetch_stage fetch_stage_i (
      .clock           (clock),
      .reset           (reset),
      .host_mode_i     (host_mode_i),
      .imem_write_i    (imem_write_i),
      .stall_i         (stall),
      .branch_taken_i  (branch_taken),
      .branch_target_i (branch_target),
      .if_id_o         (if_id)
   );

   // taken branch also kills the decode instruction
   decode_stage decode_stage_i (
      .clock   (clock),
      .reset   (reset),
      .if_id_i (if_id),
      .flush_i (branch_taken),
      .wb_i    (wb),
      .stall_o (stall),
      .id_ex_o (id_ex)
   );

   execute_stage execute_stage_i (
      .clock           (clock),
      .reset           (reset),
      .id_ex_i         (id_ex),
      .wb_i            (wb),
      .ex_mem_o        (ex_mem),
      .branch_taken_o  (branch_taken),
      .branch_target_o (branch_target)
   );

   memory_stage memory_stage_i (
      .clock       (clock),
      .reset       (reset),
      .ex_mem_i    (ex_mem),
      .dmem_addr_i (dmem_addr_i),
      .wb_o        (wb),
      .dmem_data_o (dmem_data_o)
   );

   // every register write shows on the trace
   assign trace_o = wb;

endmodule

//--- hdl/cpu_consts.svh
/* cpu constants
   datapath and instruction widths, memory depths, opcode encodings */

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and instruction word
`define CPU_XLEN        64
`define CPU_ILEN        32
`define CPU_REG_BITS    4

// word-addressed memories of 256 entries each
`define CPU_IMEM_BITS   8
`define CPU_DMEM_BITS   8

// opcodes in instruction bits 27..20
`define CPU_OP_ADD      8'h10
`define CPU_OP_SUB      8'h11
`define CPU_OP_AND      8'h12
`define CPU_OP_ORR      8'h13
`define CPU_OP_ADDI     8'h20
`define CPU_OP_SUBI     8'h21
`define CPU_OP_LDR      8'h30
`define CPU_OP_STR      8'h31
`define CPU_OP_B        8'h40
`define CPU_OP_CBZ      8'h41

`endif

//--- hdl/cpu_pkg.sv
/* cpu types
   instruction formats, control word and the pipeline stage registers */

`include "cpu_consts.svh"

package cpu_pkg;

   // three-register format
   typedef struct packed {
      logic [3:0]               spare_hi;
      logic [7:0]               opcode;
      logic [`CPU_REG_BITS-1:0] rn;
      logic [`CPU_REG_BITS-1:0] rd;
      logic [7:0]               spare_lo;
      logic [`CPU_REG_BITS-1:0] rm;
   } instr_reg_t;

   // immediate format with a signed 12-bit offset in the low bits
   typedef struct packed {
      logic [3:0]               spare_hi;
      logic [7:0]               opcode;
      logic [`CPU_REG_BITS-1:0] rn;
      logic [`CPU_REG_BITS-1:0] rd;
      logic [11:0]              imm;
   } instr_imm_t;

   typedef union packed {
      instr_reg_t reg_view;
      instr_imm_t imm_view;
   } instr_t;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_ORR
   } alu_op_t;

   typedef struct packed {
      alu_op_t alu_op;
      logic    use_imm;
      logic    mem_read;
      logic    mem_write;
      logic    reg_write;
      logic    branch;
      logic    branch_zero;
   } ctrl_t;

   typedef struct packed {
      logic                      valid;
      logic [`CPU_IMEM_BITS-1:0] pc;
      instr_t                    instr;
   } if_id_t;

   typedef struct packed {
      logic                      valid;
      ctrl_t                     ctrl;
      logic [`CPU_IMEM_BITS-1:0] pc;
      logic [`CPU_XLEN-1:0]      op_a;
      logic [`CPU_XLEN-1:0]      op_b;
      logic [`CPU_XLEN-1:0]      imm;
      logic [`CPU_REG_BITS-1:0]  rn;
      logic [`CPU_REG_BITS-1:0]  src2;
      logic [`CPU_REG_BITS-1:0]  rd;
   } id_ex_t;

   typedef struct packed {
      logic                     valid;
      ctrl_t                    ctrl;
      logic [`CPU_XLEN-1:0]     alu_result;
      logic [`CPU_XLEN-1:0]     store_data;
      logic [`CPU_REG_BITS-1:0] rd;
   } ex_mem_t;

   // register write and trace word
   typedef struct packed {
      logic                     valid;
      logic [`CPU_REG_BITS-1:0] rd;
      logic [`CPU_XLEN-1:0]     data;
   } wb_trace_t;

   typedef struct packed {
      logic                      we;
      logic [`CPU_IMEM_BITS-1:0] addr;
      logic [`CPU_ILEN-1:0]      data;
   } imem_write_t;

endpackage

//--- hdl/decode_stage.sv
/* decode stage
   control decode, write-through register file, load-use hazard detection
   and the decode/execute register */

`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage
(
   input  logic               clock,
   input  logic               reset,
   input  cpu_pkg::if_id_t    if_id_i,
   input  logic               flush_i,
   input  cpu_pkg::wb_trace_t wb_i,
   output logic               stall_o,
   output cpu_pkg::id_ex_t    id_ex_o
);

   cpu_pkg::instr_t          instr;
   cpu_pkg::ctrl_t           ctrl;
   logic [`CPU_REG_BITS-1:0] rn;
   logic [`CPU_REG_BITS-1:0] rm;
   logic [`CPU_REG_BITS-1:0] rd;
   logic [`CPU_REG_BITS-1:0] src2;
   logic                     use_rn;
   logic                     use_src2;
   logic [`CPU_XLEN-1:0]     regs [0:(1 << `CPU_REG_BITS)-1];
   logic [`CPU_XLEN-1:0]     rn_data;
   logic [`CPU_XLEN-1:0]     src2_data;
   logic [`CPU_XLEN-1:0]     imm_ext;

   assign instr = if_id_i.instr;

   // register fields from the register view and offset from the immediate view
   assign rn      = instr.reg_view.rn;
   assign rm      = instr.reg_view.rm;
   assign rd      = instr.imm_view.rd;
   assign imm_ext = {{(`CPU_XLEN-12){instr.imm_view.imm[11]}}, instr.imm_view.imm};

   always_comb
   begin
      ctrl = '0;
      case (instr.reg_view.opcode)
         `CPU_OP_ADD:
         begin
            ctrl.alu_op    = cpu_pkg::ALU_ADD;
            ctrl.reg_write = 1'b1;
         end
         `CPU_OP_SUB:
         begin
            ctrl.alu_op    = cpu_pkg::ALU_SUB;
            ctrl.reg_write = 1'b1;
         end
         `CPU_OP_AND:
         begin
            ctrl.alu_op    = cpu_pkg::ALU_AND;
            ctrl.reg_write = 1'b1;
         end
         `CPU_OP_ORR:
         begin
            ctrl.alu_op    = cpu_pkg::ALU_ORR;
            ctrl.reg_write = 1'b1;
         end
         `CPU_OP_ADDI:
         begin
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         `CPU_OP_SUBI:
         begin
            ctrl.alu_op    = cpu_pkg::ALU_SUB;
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         `CPU_OP_LDR:
         begin
            // address is rn plus offset
            ctrl.use_imm   = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         `CPU_OP_STR:
         begin
            ctrl.use_imm   = 1'b1;
            ctrl.mem_write = 1'b1;
         end
         `CPU_OP_B:   ctrl.branch      = 1'b1;
         `CPU_OP_CBZ: ctrl.branch_zero = 1'b1;
         // anything else runs as a nop
         default:     ctrl = '0;
      endcase
   end

   // store data and the cbz test register sit in the rd field
   assign src2 = (ctrl.mem_write || ctrl.branch_zero) ? rd : rm;

   // which sources the instruction really reads
   assign use_rn   = ctrl.reg_write || ctrl.mem_write;
   assign use_src2 = (ctrl.reg_write && !ctrl.use_imm) || ctrl.mem_write || ctrl.branch_zero;

   // hold one cycle when a load in execute feeds this instruction
   assign stall_o = if_id_i.valid && id_ex_o.valid && id_ex_o.ctrl.mem_read &&
                    ((use_rn && id_ex_o.rd == rn) || (use_src2 && id_ex_o.rd == src2));

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < (1 << `CPU_REG_BITS); i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wb_i.valid)
      begin
         regs[wb_i.rd] <= wb_i.data;
      end
   end

   // write-through where a same-cycle write-back wins over the array
   assign rn_data   = (wb_i.valid && wb_i.rd == rn) ? wb_i.data : regs[rn];
   assign src2_data = (wb_i.valid && wb_i.rd == src2) ? wb_i.data : regs[src2];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         id_ex_o.valid <= 1'b0;
      end
      else
      begin
         // bubble on stall and kill on a taken branch
         id_ex_o.valid <= if_id_i.valid && !stall_o && !flush_i;
         id_ex_o.ctrl  <= ctrl;
         id_ex_o.pc    <= if_id_i.pc;
         id_ex_o.op_a  <= rn_data;
         id_ex_o.op_b  <= src2_data;
         id_ex_o.imm   <= imm_ext;
         id_ex_o.rn    <= rn;
         id_ex_o.src2  <= src2;
         id_ex_o.rd    <= rd;
      end
   end

endmodule

//--- hdl/execute_stage.sv
/* execute stage
   operand forwarding, alu, branch resolution, execute/memory register */

`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_stage
(
   input  logic                      clock,
   input  logic                      reset,
   input  cpu_pkg::id_ex_t           id_ex_i,
   input  cpu_pkg::wb_trace_t        wb_i,
   output cpu_pkg::ex_mem_t          ex_mem_o,
   output logic                      branch_taken_o,
   output logic [`CPU_IMEM_BITS-1:0] branch_target_o
);

   logic [`CPU_XLEN-1:0] fwd_a;
   logic [`CPU_XLEN-1:0] fwd_b;
   logic [`CPU_XLEN-1:0] alu_b;
   logic [`CPU_XLEN-1:0] alu_result;

   // newest producer first; load data only comes from write-back
   function automatic logic [`CPU_XLEN-1:0] fwd_sel
   (
      input logic [`CPU_REG_BITS-1:0] src,
      input logic [`CPU_XLEN-1:0]     reg_val,
      input cpu_pkg::ex_mem_t         ex_mem,
      input cpu_pkg::wb_trace_t       wb
   );
      logic ex_hit;
      ex_hit = ex_mem.valid && ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read &&
               ex_mem.rd == src;
      if (ex_hit)
      begin
         return ex_mem.alu_result;
      end
      else if (wb.valid && wb.rd == src)
      begin
         return wb.data;
      end
      return reg_val;
   endfunction

   assign fwd_a = fwd_sel(id_ex_i.rn, id_ex_i.op_a, ex_mem_o, wb_i);
   assign fwd_b = fwd_sel(id_ex_i.src2, id_ex_i.op_b, ex_mem_o, wb_i);

   // immediate forms and memory addressing take the sign-extended offset
   assign alu_b = id_ex_i.ctrl.use_imm ? id_ex_i.imm : fwd_b;

   always_comb
   begin
      case (id_ex_i.ctrl.alu_op)
         cpu_pkg::ALU_SUB: alu_result = fwd_a - alu_b;
         cpu_pkg::ALU_AND: alu_result = fwd_a & alu_b;
         cpu_pkg::ALU_ORR: alu_result = fwd_a | alu_b;
         default:          alu_result = fwd_a + alu_b;
      endcase
   end

   // b always taken and cbz on a zero test register
   assign branch_taken_o  = id_ex_i.valid &&
                            (id_ex_i.ctrl.branch ||
                             (id_ex_i.ctrl.branch_zero && fwd_b == '0));
   // pc-relative target wrapping within instruction memory
   assign branch_target_o = id_ex_i.pc + id_ex_i.imm[`CPU_IMEM_BITS-1:0];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         ex_mem_o.valid <= 1'b0;
      end
      else
      begin
         // a taken branch retires here with no write
         ex_mem_o.valid      <= id_ex_i.valid && !branch_taken_o;
         ex_mem_o.ctrl       <= id_ex_i.ctrl;
         ex_mem_o.alu_result <= alu_result;
         ex_mem_o.store_data <= fwd_b;
         ex_mem_o.rd         <= id_ex_i.rd;
      end
   end

endmodule

//--- hdl/fetch_stage.sv
/* fetch stage
   program counter, host-written instruction memory, fetch/decode register */

`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_stage
(
   input  logic                      clock,
   input  logic                      reset,
   input  logic                      host_mode_i,
   input  cpu_pkg::imem_write_t      imem_write_i,
   input  logic                      stall_i,
   input  logic                      branch_taken_i,
   input  logic [`CPU_IMEM_BITS-1:0] branch_target_i,
   output cpu_pkg::if_id_t           if_id_o
);

   logic [`CPU_ILEN-1:0]      imem [0:(1 << `CPU_IMEM_BITS)-1];
   logic [`CPU_IMEM_BITS-1:0] pc_q;
   logic [`CPU_ILEN-1:0]      fetch_word;

   // asynchronous read at the current pc
   assign fetch_word = imem[pc_q];

   // host write port
   always_ff @(posedge clock)
   begin
      if (imem_write_i.we)
      begin
         imem[imem_write_i.addr] <= imem_write_i.data;
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         pc_q          <= '0;
         if_id_o.valid <= 1'b0;
      end
      else if (host_mode_i)
      begin
         // core held so restart from word 0 once released
         pc_q          <= '0;
         if_id_o.valid <= 1'b0;
      end
      else if (branch_taken_i)
      begin
         // redirect and drop the word in flight
         pc_q          <= branch_target_i;
         if_id_o.valid <= 1'b0;
      end
      else if (!stall_i)
      begin
         pc_q          <= pc_q + 1'b1;
         if_id_o.valid <= 1'b1;
         if_id_o.pc    <= pc_q;
         if_id_o.instr <= fetch_word;
      end
      // load-use stall holds pc and fetch/decode register
   end

endmodule

//--- hdl/memory_stage.sv
/* memory stage
   dual-port data memory, memory/write-back register and write-back select */

`timescale 1ns/1ps
`include "cpu_consts.svh"

module memory_stage
(
   input  logic                      clock,
   input  logic                      reset,
   input  cpu_pkg::ex_mem_t          ex_mem_i,
   input  logic [`CPU_DMEM_BITS-1:0] dmem_addr_i,
   output cpu_pkg::wb_trace_t        wb_o,
   output logic [`CPU_XLEN-1:0]      dmem_data_o
);

   logic [`CPU_XLEN-1:0]      dmem [0:(1 << `CPU_DMEM_BITS)-1];
   logic [`CPU_DMEM_BITS-1:0] addr;
   logic [`CPU_XLEN-1:0]      load_q;
   logic [`CPU_XLEN-1:0]      host_q;
   logic                      wb_valid_q;
   logic                      wb_load_q;
   logic [`CPU_REG_BITS-1:0]  wb_rd_q;
   logic [`CPU_XLEN-1:0]      wb_alu_q;

   // doubleword index from the low address bits
   assign addr = ex_mem_i.alu_result[`CPU_DMEM_BITS-1:0];

   // pipeline port with synchronous read and write
   always_ff @(posedge clock)
   begin
      if (ex_mem_i.valid && ex_mem_i.ctrl.mem_write)
      begin
         dmem[addr] <= ex_mem_i.store_data;
      end
      load_q <= dmem[addr];
   end

   // host read port with one cycle latency
   always_ff @(posedge clock)
   begin
      host_q <= dmem[dmem_addr_i];
   end

   assign dmem_data_o = host_q;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wb_valid_q <= 1'b0;
      end
      else
      begin
         wb_valid_q <= ex_mem_i.valid && ex_mem_i.ctrl.reg_write;
         wb_load_q  <= ex_mem_i.ctrl.mem_read;
         wb_rd_q    <= ex_mem_i.rd;
         wb_alu_q   <= ex_mem_i.alu_result;
      end
   end

   // load data lands alongside the registered alu result
   assign wb_o.valid = wb_valid_q;
   assign wb_o.rd    = wb_rd_q;
   assign wb_o.data  = wb_load_q ? load_q : wb_alu_q;

endmodule

//--- project.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/arm_pipeline.sv
test/arm_pipeline_sva.sv
test/arm_pipeline_tb.sv

//--- test/arm_pipeline_sva.sv
/* trace port assertions
   reset, known-value and host-hold rules on the write-back trace */

`timescale 1ns/1ps

module arm_pipeline_sva
(
   input logic               clock,
   input logic               reset,
   input logic               host_mode_i,
   input cpu_pkg::wb_trace_t trace_i
);

   logic [2:0] host_cycles;

   // consecutive host-mode cycles saturating at 7
   always_ff @(posedge clock)
   begin
      if (reset || !host_mode_i)
      begin
         host_cycles <= '0;
      end
      else if (host_cycles != 3'd7)
      begin
         host_cycles <= host_cycles + 3'd1;
      end
   end

   // write-back register cleared by reset
   assert property (@(posedge clock) reset |=> !trace_i.valid)
      else $error("trace valid in the cycle after reset");

   assert property (@(posedge clock) disable iff (reset)
                    trace_i.valid |-> !$isunknown(trace_i))
      else $error("trace carries unknown bits while valid");

   // pipeline fully drained after six held cycles
   assert property (@(posedge clock) disable iff (reset)
                    (host_mode_i && host_cycles >= 3'd5) |-> !trace_i.valid)
      else $error("trace valid after six cycles of host mode");

endmodule

bind arm_pipeline arm_pipeline_sva arm_pipeline_sva_i (
   .clock       (clock),
   .reset       (reset),
   .host_mode_i (host_mode_i),
   .trace_i     (trace_o)
);

//--- test/arm_pipeline_tb.sv
/* testbench for the pipelined core
   random programs run against an instruction-set model,
   write-back trace and data memory compared in order */

`timescale 1ns/1ps
`include "cpu_consts.svh"

module arm_pipeline_tb;

   localparam logic [31:0] seed       = 32'hf9fe_bd35;
   localparam int          body_len   = 48;
   localparam int          wait_limit = 4000;

   logic                      clock;
   logic                      reset;
   logic                      host_mode_i;
   cpu_pkg::imem_write_t      imem_write_i;
   logic [`CPU_DMEM_BITS-1:0] dmem_addr_i;
   logic [`CPU_XLEN-1:0]      dmem_data_o;
   cpu_pkg::wb_trace_t        trace_o;

   // model state carried over between programs
   logic [31:0]               rng_state;
   logic [`CPU_ILEN-1:0]      prog [0:(1 << `CPU_IMEM_BITS)-1];
   int                        prog_len;
   logic [`CPU_XLEN-1:0]      model_regs [0:(1 << `CPU_REG_BITS)-1];
   logic [`CPU_XLEN-1:0]      model_mem [0:(1 << `CPU_DMEM_BITS)-1];
   logic                      model_stored [0:(1 << `CPU_DMEM_BITS)-1];
   logic [`CPU_DMEM_BITS-1:0] stored_q [$];
   logic [`CPU_DMEM_BITS-1:0] last_stored;
   logic [`CPU_REG_BITS-1:0]  last_rd;
   cpu_pkg::wb_trace_t        expect_q [$];
   cpu_pkg::wb_trace_t        mon_exp;

   arm_pipeline arm_pipeline_i (
      .clock        (clock),
      .reset        (reset),
      .host_mode_i  (host_mode_i),
      .imem_write_i (imem_write_i),
      .dmem_addr_i  (dmem_addr_i),
      .dmem_data_o  (dmem_data_o),
      .trace_o      (trace_o)
   );

   // 40 ns period
   always #20 clock = ~clock;

   task automatic report_failure();
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_trace(input cpu_pkg::wb_trace_t got, input cpu_pkg::wb_trace_t exp);
      if (got !== exp)
      begin
         $display("Fail at %0t: trace_o got r%0d=%h, expected r%0d=%h",
                  $time, got.rd, got.data, exp.rd, exp.data);
         report_failure();
      end
   endtask

   task automatic check_word(input string name, input logic [`CPU_XLEN-1:0] got,
                             input logic [`CPU_XLEN-1:0] exp);
      if (got !== exp)
      begin
         $display("Fail at %0t: %s got %h, expected %h", $time, name, got, exp);
         report_failure();
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // field order is spare nibble, opcode, rn, rd and then rm or the offset
   function automatic logic [31:0] enc_reg(input logic [7:0] op, input logic [3:0] rn,
                                           input logic [3:0] rd, input logic [3:0] rm);
      return {4'h0, op, rn, rd, 8'h00, rm};
   endfunction

   function automatic logic [31:0] enc_imm(input logic [7:0] op, input logic [3:0] rn,
                                           input logic [3:0] rd, input logic [11:0] imm);
      return {4'h0, op, rn, rd, imm};
   endfunction

   function automatic logic [`CPU_XLEN-1:0] sext12(input logic [11:0] imm);
      return {{(`CPU_XLEN-12){imm[11]}}, imm};
   endfunction

   function automatic logic [`CPU_XLEN-1:0] alu_model(input logic [7:0] op,
                                                      input logic [`CPU_XLEN-1:0] a,
                                                      input logic [`CPU_XLEN-1:0] b);
      case (op)
         `CPU_OP_SUB, `CPU_OP_SUBI: return a - b;
         `CPU_OP_AND:               return a & b;
         `CPU_OP_ORR:               return a | b;
         default:                   return a + b;
      endcase
   endfunction

   // retire a register write in the model and queue its trace entry
   task automatic write_reg(input logic [3:0] rd, input logic [`CPU_XLEN-1:0] data);
      cpu_pkg::wb_trace_t entry;
      model_regs[rd] = data;
      entry.valid    = 1'b1;
      entry.rd       = rd;
      entry.data     = data;
      expect_q.push_back(entry);
   endtask

   // builds the program while the model executes it so loads hit stored words
   task automatic gen_program();
      int          pc;
      int          kind;
      int          off;
      logic        taken;
      logic [31:0] r;
      logic [3:0]  rn;
      logic [3:0]  rm;
      logic [3:0]  rd;
      logic [3:0]  src;
      logic [11:0] imm;
      logic [7:0]  op;
      logic [7:0]  addr;
      pc = 0;
      while (pc < body_len)
      begin
         r    = next_rand();
         kind = int'(next_rand() % 16);
         // r0 stays zero as the memory base
         rd   = 4'(r[7:4] % 15 + 1);
         rn   = r[8] ? last_rd : r[15:12];
         rm   = r[9] ? last_rd : r[19:16];
         src  = r[10] ? last_rd : r[23:20];
         imm  = {{4{r[31]}}, r[31:24]};
         if (kind inside {[10:11]} && stored_q.size() == 0)
         begin
            kind = 8;
         end
         taken = 1'b0;
         off   = 1;
         case (kind)
            0, 1, 2, 3, 4:
            begin
               case (r[1:0])
                  2'd0:    op = `CPU_OP_ADD;
                  2'd1:    op = `CPU_OP_SUB;
                  2'd2:    op = `CPU_OP_AND;
                  default: op = `CPU_OP_ORR;
               endcase
               prog[pc] = enc_reg(op, rn, rd, rm);
               write_reg(rd, alu_model(op, model_regs[rn], model_regs[rm]));
               last_rd = rd;
            end
            5, 6, 7:
            begin
               op       = r[2] ? `CPU_OP_SUBI : `CPU_OP_ADDI;
               prog[pc] = enc_imm(op, rn, rd, imm);
               write_reg(rd, alu_model(op, model_regs[rn], sext12(imm)));
               last_rd = rd;
            end
            8, 9:
            begin
               // store data register sits in the rd field
               imm      = {6'h00, r[29:24]};
               addr     = 8'(model_regs[0] + sext12(imm));
               prog[pc] = enc_imm(`CPU_OP_STR, 4'h0, src, imm);
               model_mem[addr] = model_regs[src];
               if (!model_stored[addr])
               begin
                  stored_q.push_back(addr);
               end
               model_stored[addr] = 1'b1;
               last_stored        = addr;
            end
            10, 11:
            begin
               addr     = r[0] ? last_stored : stored_q[r[30:24] % stored_q.size()];
               imm      = {4'h0, addr};
               prog[pc] = enc_imm(`CPU_OP_LDR, 4'h0, rd, imm);
               write_reg(rd, model_mem[8'(model_regs[0] + sext12(imm))]);
               last_rd = rd;
            end
            12, 13, 14:
            begin
               // forward only and never past the marker
               off = 1 + int'(r[1:0]);
               if (pc + off > body_len)
               begin
                  off = body_len - pc;
               end
               imm = 12'(off);
               if (kind == 12)
               begin
                  prog[pc] = enc_imm(`CPU_OP_B, 4'h0, 4'h0, imm);
                  taken    = 1'b1;
               end
               else
               begin
                  prog[pc] = enc_imm(`CPU_OP_CBZ, 4'h0, src, imm);
                  taken    = (model_regs[src] == '0);
               end
            end
            // unassigned opcode runs as a nop
            default: prog[pc] = enc_reg(8'h00, rn, rd, rm);
         endcase
         if (taken)
         begin
            // skipped slots write a register if they ever execute
            for (int k = 1; k < off; k++)
            begin
               prog[pc + k] = enc_imm(`CPU_OP_ADDI, 4'h0, rd, 12'h5a5);
            end
            pc = pc + off;
         end
         else
         begin
            pc = pc + 1;
         end
      end
      // marker write then a branch to itself and two nop words
      prog[body_len] = enc_imm(`CPU_OP_ADDI, 4'h0, 4'hf, 12'h7ee);
      write_reg(4'hf, alu_model(`CPU_OP_ADDI, model_regs[0], sext12(12'h7ee)));
      prog[body_len + 1] = enc_imm(`CPU_OP_B, 4'h0, 4'h0, 12'h000);
      prog[body_len + 2] = '0;
      prog[body_len + 3] = '0;
      prog_len           = body_len + 4;
   endtask

   task automatic load_program();
      cpu_pkg::imem_write_t wr;
      for (int i = 0; i < prog_len; i++)
      begin
         wr.we   = 1'b1;
         wr.addr = 8'(i);
         wr.data = prog[i];
         @(posedge clock);
         imem_write_i <= wr;
      end
      @(posedge clock);
      imem_write_i <= '0;
   endtask

   task automatic wait_trace_drained();
      int cycles;
      cycles = 0;
      while (expect_q.size() != 0)
      begin
         @(posedge clock);
         cycles++;
         if (cycles > wait_limit)
         begin
            $display("timeout, %0d trace writes still missing after %0d cycles",
                     expect_q.size(), wait_limit);
            report_failure();
         end
      end
   endtask

   // host read port one cycle behind the address
   task automatic read_back_memory();
      foreach (stored_q[i])
      begin
         @(posedge clock);
         dmem_addr_i <= stored_q[i];
         @(posedge clock);
         @(negedge clock);
         check_word("dmem_data_o", dmem_data_o, model_mem[stored_q[i]]);
      end
   endtask

   task automatic run_program();
      load_program();
      @(posedge clock);
      host_mode_i <= 1'b0;
      wait_trace_drained();
      read_back_memory();
   endtask

   // in-order trace check where any write past the model's list is an error
   always @(negedge clock)
   begin
      if (!reset && trace_o.valid === 1'b1)
      begin
         if (expect_q.size() == 0)
         begin
            $display("unexpected write-back to r%0d at %0t", trace_o.rd, $time);
            report_failure();
         end
         else
         begin
            mon_exp = expect_q.pop_front();
            check_trace(trace_o, mon_exp);
         end
      end
   end

   initial
   begin
      clock        = 1'b0;
      reset        = 1'b1;
      host_mode_i  = 1'b1;
      imem_write_i = '0;
      dmem_addr_i  = '0;
      rng_state    = seed;
      last_rd      = 4'd1;
      last_stored  = '0;
      prog_len     = 0;
      for (int i = 0; i < (1 << `CPU_REG_BITS); i++)
      begin
         model_regs[i] = '0;
      end
      for (int i = 0; i < (1 << `CPU_DMEM_BITS); i++)
      begin
         model_mem[i]    = '0;
         model_stored[i] = 1'b0;
      end
      repeat (10) @(posedge clock);
      reset <= 1'b0;
      // first program from a cleared register file
      gen_program();
      run_program();
      // second program with registers and memory carried over
      @(posedge clock);
      host_mode_i <= 1'b1;
      repeat (8) @(posedge clock);
      gen_program();
      run_program();
      $display("All tests passed");
      $finish;
   end

endmodule
